//--- qerv_lite.f
verilog/qerv_pkg.sv
verilog/qerv_state.sv
verilog/qerv_decode.sv
verilog/qerv_immdec.sv
verilog/qerv_alu.sv
verilog/qerv_ctrl.sv
verilog/qerv_top.sv
verification/qerv_sva.sv
verification/qerv_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module qerv_tb -f qerv_lite.f -o qerv_sim

status=0
output="$(./obj_dir/qerv_sim 2>&1)" || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1

//--- verification/qerv_sva.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_sva (
   input wire clk,
   input wire i_arst_n,
   input wire i_ibus_cyc,
   input wire i_ibus_ack,
   input wire i_rf_rreq,
   input wire i_wen0
);

   int fail_cnt = 0;

   // Read request is a one-cycle strobe
   a_rreq_single: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rf_rreq |=> !i_rf_rreq)
   else begin
      $error("register file read request high for two cycles in a row");
      fail_cnt++;
   end

   a_cyc_until_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_ibus_cyc && !i_ibus_ack) |=> i_ibus_cyc)
   else begin
      $error("instruction bus cyc dropped before ack");
      fail_cnt++;
   end

   // No write-back while fetching
   a_wen_not_cyc: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(i_wen0 && i_ibus_cyc))
   else begin
      $error("write enable and instruction bus cyc high together");
      fail_cnt++;
   end

endmodule

bind qerv_top qerv_sva u_sva (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_rf_rreq  (o_rf_rreq),
   .i_wen0     (o_wen0)
);

`default_nettype wire

//--- verification/qerv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_tb;
   import qerv_pkg::*;

   localparam word_t      RESET_PC   = 32'h0000_1000;
   localparam int         CLK_PERIOD = 20;
   localparam int         N_INSTR    = 400;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [2:0] F3_GOOD [4] = '{3'b000, 3'b100, 3'b110, 3'b111};
   localparam logic [2:0] F3_BAD [4]  = '{3'b001, 3'b010, 3'b011, 3'b101};
   localparam logic [6:0] OPC_BAD [4] = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111};

   logic      clk;
   logic      arst_n;
   word_t     ibus_adr;
   logic      ibus_cyc;
   word_t     ibus_rdt;
   logic      ibus_ack;
   logic      rf_rreq;
   logic      rf_ready;
   reg_addr_t rreg0;
   reg_addr_t rreg1;
   reg_addr_t wreg0;
   nib_t      rdata0;
   nib_t      rdata1;
   nib_t      wdata0;
   logic      wen0;

   integer    seed;
   word_t     regs [32];
   int        err_fetch;
   int        err_rf;
   int        err_wb;

   qerv_top #(
      .RESET_PC (RESET_PC)
   ) i_dut (
      .clk        (clk),
      .i_arst_n   (arst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_rreq  (rf_rreq),
      .i_rf_ready (rf_ready),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_wreg0    (wreg0),
      .o_wen0     (wen0),
      .o_wdata0   (wdata0)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_INSTR * 24 * CLK_PERIOD);
      $display("Timeout: the core stopped before all %0d instructions were checked", N_INSTR);
      $display("RESULT: FAIL");
      $finish;
   end

   // Kinds 0-4 OP, 5-8 OP-IMM, 9 LUI, 10-12 unsupported
   task automatic make_instr(output word_t instr);
      int    kind;
      word_t rnd;
      kind  = {$random(seed)} % 13;
      rnd   = $random(seed);
      instr = $random(seed);
      if (kind <= 4) begin
         instr[6:0]   = OPC_OP;
         instr[31:25] = (kind == 1) ? 7'b0100000 : 7'b0000000;
         instr[14:12] = (kind <= 1) ? 3'b000 : F3_GOOD[kind - 1];
      end else if (kind <= 8) begin
         instr[6:0]   = OPC_OP_IMM;
         instr[14:12] = F3_GOOD[kind - 5];
      end else if (kind == 9) begin
         instr[6:0] = OPC_LUI;
      end else if (kind == 12) begin
         instr[6:0] = OPC_BAD[rnd[3:2]];
      end else begin
         instr[6:0]   = (kind == 10) ? OPC_OP : OPC_OP_IMM;
         instr[14:12] = F3_BAD[rnd[1:0]];
      end
   endtask

   task automatic model_exec(input word_t instr, input word_t a, input word_t b,
                             output logic we, output word_t res);
      logic [6:0] opc;
      logic       ok;
      word_t      op_b;
      opc  = instr[6:0];
      ok   = 1'b1;
      res  = '0;
      op_b = (opc == OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : b;
      if (opc == OPC_LUI) begin
         res = {instr[31:12], 12'h000};
      end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
         case (instr[14:12])
            3'b000:  res = (opc == OPC_OP && instr[30]) ? a - op_b : a + op_b;
            3'b100:  res = a ^ op_b;
            3'b110:  res = a | op_b;
            3'b111:  res = a & op_b;
            default: ok = 1'b0;
         endcase
      end else begin
         ok = 1'b0;
      end
      we = ok && (instr[11:7] != 5'd0);
   endtask

   initial begin
      word_t instr;
      word_t exp_pc;
      word_t a;
      word_t b;
      word_t res;
      word_t got;
      logic  we;
      int    dly;
      int    err_sva;
      seed      = 32'h74db_e3bf;
      err_fetch = 0;
      err_rf    = 0;
      err_wb    = 0;
      arst_n    = 1'b0;
      ibus_rdt  = '0;
      ibus_ack  = 1'b0;
      rf_ready  = 1'b0;
      rdata0    = '0;
      rdata1    = '0;
      for (int i = 0; i < 32; i++) begin
         regs[i] = $random(seed);
      end
      regs[0] = '0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      exp_pc = RESET_PC;

      for (int n = 0; n < N_INSTR; n++) begin
         while (!ibus_cyc) @(negedge clk);
         assert (ibus_adr == exp_pc) else begin
            err_fetch++;
            $display("[ERROR] %0t: fetch %0d at %h, expected %h", $time, n, ibus_adr, exp_pc);
         end
         make_instr(instr);
         dly = {$random(seed)} % 4;
         repeat (dly) @(negedge clk);
         ibus_ack = 1'b1;
         ibus_rdt = instr;
         @(negedge clk);
         ibus_ack = 1'b0;
         ibus_rdt = $random(seed);
         assert (rf_rreq && !ibus_cyc && rreg0 == instr[19:15] &&
                 rreg1 == instr[24:20]) else begin
            err_rf++;
            $display("[ERROR] %0t: read request %b cyc %b rs1 %0d rs2 %0d for instr %h",
                     $time, rf_rreq, ibus_cyc, rreg0, rreg1, instr);
         end
         a = regs[instr[19:15]];
         b = regs[instr[24:20]];
         model_exec(instr, a, b, we, res);

         // Register file answers, then serves nibbles LSB first
         dly = 1 + {$random(seed)} % 3;
         repeat (dly) @(negedge clk);
         rf_ready = 1'b1;
         got      = '0;
         for (int k = 0; k < CNT_LEN; k++) begin
            @(negedge clk);
            rf_ready = 1'b0;
            rdata0   = a[k*W +: W];
            rdata1   = b[k*W +: W];
            #(CLK_PERIOD / 4);
            assert (wen0 == we && (!we || wreg0 == instr[11:7])) else begin
               err_wb++;
               $display("[ERROR] %0t: write enable %b rd %0d for instr %h, expected %b rd %0d",
                        $time, wen0, wreg0, instr, we, instr[11:7]);
            end
            got[k*W +: W] = wdata0;
         end
         if (we) begin
            assert (got == res) else begin
               err_wb++;
               $display("[ERROR] %0t: instr %h result %h, expected %h", $time, instr, got, res);
            end
            regs[instr[11:7]] = res;
         end
         exp_pc = exp_pc + 32'd4;
      end

      err_sva = i_dut.u_sva.fail_cnt;
      $display("Errors: fetch %0d, register read %0d, write-back %0d, assertions %0d",
               err_fetch, err_rf, err_wb, err_sva);
      if (err_fetch + err_rf + err_wb + err_sva == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/qerv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_alu (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_run,
   input  wire                  i_cnt0,
   input  wire qerv_pkg::ctrl_t i_ctrl,
   input  wire qerv_pkg::nib_t  i_rs1,
   input  wire qerv_pkg::nib_t  i_rs2,
   input  wire qerv_pkg::nib_t  i_imm,
   output qerv_pkg::nib_t       o_rd
);
   import qerv_pkg::*;

   nib_t       op_b;
   nib_t       op_b_add;
   logic       carry_q;
   logic       carry_in;
   logic [W:0] sum;

   assign op_b     = i_ctrl.op_b_imm ? i_imm : i_rs2;
   assign op_b_add = op_b ^ {W{i_ctrl.sub}};

   // Subtract injects the +1 of two's complement on the first nibble
   assign carry_in = i_cnt0 ? i_ctrl.sub : carry_q;
   assign sum      = {1'b0, i_rs1} + {1'b0, op_b_add} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
      end else if (i_run) begin
         carry_q <= sum[W];
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         ALU_OR:  o_rd = i_rs1 | op_b;
         ALU_AND: o_rd = i_rs1 & op_b;
         ALU_IMM: o_rd = i_imm;
         default: o_rd = sum[W-1:0];
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/qerv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_ctrl #(
   parameter qerv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire             clk,
   input  wire             i_arst_n,
   input  wire             i_run,
   input  wire             i_cnt0,
   output qerv_pkg::word_t o_pc
);
   import qerv_pkg::*;

   word_t      pc_q;
   logic       carry_q;
   logic       carry_in;
   nib_t       step;
   logic [W:0] sum;

   // Add 4 on the first nibble, then ripple the carry
   assign step     = i_cnt0 ? nib_t'(4) : '0;
   assign carry_in = i_cnt0 ? 1'b0 : carry_q;
   assign sum      = {1'b0, pc_q[W-1:0]} + {1'b0, step} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q    <= RESET_PC;
         carry_q <= 1'b0;
      end else if (i_run) begin
         pc_q    <= {sum[W-1:0], pc_q[XLEN-1:W]};
         carry_q <= sum[W];
      end
   end

   assign o_pc = pc_q;

endmodule

`default_nettype wire

//--- verilog/qerv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_decode (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_ibus_ack,
   input  wire qerv_pkg::word_t i_instr,
   output qerv_pkg::ctrl_t      o_ctrl
);
   import qerv_pkg::*;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam ctrl_t      CTRL_NOP   = '{ALU_ADD, 1'b0, 1'b0, 1'b0};

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       supported;
   ctrl_t      ctrl_d;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];

   always_comb begin
      ctrl_d    = CTRL_NOP;
      supported = 1'b0;
      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            supported       = 1'b1;
            ctrl_d.op_b_imm = (opcode == OPC_OP_IMM);
            case (funct3)
               // ADDI has no subtract form
               3'b000:  ctrl_d.sub    = (opcode == OPC_OP) & i_instr[30];
               3'b100:  ctrl_d.alu_op = ALU_XOR;
               3'b110:  ctrl_d.alu_op = ALU_OR;
               3'b111:  ctrl_d.alu_op = ALU_AND;
               default: supported     = 1'b0;
            endcase
         end
         OPC_LUI: begin
            supported       = 1'b1;
            ctrl_d.alu_op   = ALU_IMM;
            ctrl_d.op_b_imm = 1'b1;
         end
         default: supported = 1'b0;
      endcase
      ctrl_d.rd_we = supported & (i_instr[11:7] != 5'd0);
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ctrl <= CTRL_NOP;
      end else if (i_ibus_ack) begin
         o_ctrl <= ctrl_d;
      end
   end

endmodule

`default_nettype wire

//--- verilog/qerv_immdec.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_immdec (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_ibus_ack,
   input  wire qerv_pkg::word_t i_instr,
   input  wire                  i_run,
   output qerv_pkg::reg_addr_t  o_rs1_addr,
   output qerv_pkg::reg_addr_t  o_rs2_addr,
   output qerv_pkg::reg_addr_t  o_rd_addr,
   output qerv_pkg::nib_t       o_imm
);
   import qerv_pkg::*;

   word_t imm_q;
   word_t imm_d;

   // U-type opcodes have bit 2 set
   assign imm_d = i_instr[2] ? {i_instr[31:12], 12'h000}
                             : {{20{i_instr[31]}}, i_instr[31:20]};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rs1_addr <= '0;
         o_rs2_addr <= '0;
         o_rd_addr  <= '0;
      end else if (i_ibus_ack) begin
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
         o_rd_addr  <= i_instr[11:7];
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= imm_d;
      end else if (i_run) begin
         imm_q <= {{W{1'b0}}, imm_q[XLEN-1:W]};
      end
   end

   assign o_imm = imm_q[W-1:0];

endmodule

`default_nettype wire

//--- verilog/qerv_pkg.sv
`default_nettype none

package qerv_pkg;

   // Serial datapath geometry
   localparam int W       = 4;
   localparam int XLEN    = 32;
   localparam int CNT_LEN = XLEN / W;

   typedef logic [W-1:0]    nib_t;
   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [2:0]      cnt_t;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_RREQ,
      ST_WAIT_RF,
      ST_RUN
   } state_e;

   // Source of the result nibble
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_IMM
   } alu_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    sub;
      logic    op_b_imm;
      logic    rd_we;
   } ctrl_t;

endpackage

`default_nettype wire

//--- verilog/qerv_state.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_state (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_ibus_ack,
   input  wire                  i_rf_ready,
   input  wire qerv_pkg::ctrl_t i_ctrl,
   output logic                 o_ibus_cyc,
   output logic                 o_rf_rreq,
   output logic                 o_run,
   output logic                 o_cnt0,
   output logic                 o_wen0
);
   import qerv_pkg::*;

   state_e state;
   cnt_t   cnt;
   logic   cnt_last;

   assign cnt_last = (cnt == cnt_t'(CNT_LEN - 1));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= ST_FETCH;
         cnt   <= '0;
      end else begin
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_RREQ;
               end
            end
            ST_RREQ: begin
               state <= ST_WAIT_RF;
            end
            ST_WAIT_RF: begin
               if (i_rf_ready) begin
                  state <= ST_RUN;
                  cnt   <= '0;
               end
            end
            default: begin
               cnt <= cnt + 1'b1;
               if (cnt_last) begin
                  state <= ST_FETCH;
               end
            end
         endcase
      end
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_rf_rreq  = (state == ST_RREQ);
   assign o_run      = (state == ST_RUN);
   assign o_cnt0     = o_run & (cnt == '0);

   // Only write-enable decision in the core
   assign o_wen0 = o_run & i_ctrl.rd_we;

endmodule

`default_nettype wire

//--- verilog/qerv_top.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_top #(
   parameter qerv_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  wire                  clk,
   input  wire                  i_arst_n,
   // Instruction bus
   output qerv_pkg::word_t      o_ibus_adr,
   output logic                 o_ibus_cyc,
   input  wire qerv_pkg::word_t i_ibus_rdt,
   input  wire                  i_ibus_ack,
   // Register file
   output logic                 o_rf_rreq,
   input  wire                  i_rf_ready,
   output qerv_pkg::reg_addr_t  o_rreg0,
   output qerv_pkg::reg_addr_t  o_rreg1,
   input  wire qerv_pkg::nib_t  i_rdata0,
   input  wire qerv_pkg::nib_t  i_rdata1,
   output qerv_pkg::reg_addr_t  o_wreg0,
   output logic                 o_wen0,
   output qerv_pkg::nib_t       o_wdata0
);
   import qerv_pkg::*;

   ctrl_t ctrl;
   logic  run;
   logic  cnt0;
   nib_t  imm;

   qerv_state u_state (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_ctrl     (ctrl),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_run      (run),
      .o_cnt0     (cnt0),
      .o_wen0     (o_wen0)
   );

   qerv_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .o_ctrl     (ctrl)
   );

   qerv_immdec u_immdec (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .i_run      (run),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (o_wreg0),
      .o_imm      (imm)
   );

   qerv_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_run    (run),
      .i_cnt0   (cnt0),
      .i_ctrl   (ctrl),
      .i_rs1    (i_rdata0),
      .i_rs2    (i_rdata1),
      .i_imm    (imm),
      .o_rd     (o_wdata0)
   );

   qerv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_run    (run),
      .i_cnt0   (cnt0),
      .o_pc     (o_ibus_adr)
   );

endmodule

`default_nettype wire
